// File: vlog.f
rtl/dcache_pkg.sv
rtl/dcache_req_buf.sv
rtl/dcache_store.sv
rtl/dcache_rd_sel.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tb/dcache_asserts.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_req_buf.sv
      - rtl/dcache_store.sv
      - rtl/dcache_rd_sel.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: simulation
    files:
      - tb/dcache_asserts.sv
      - tb/dcache_tb.sv

// File: tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int MEM_WORDS   = 16384;
    localparam int RAND_OPS    = 200;
    localparam int NUM_REQS    = 8 + 14 + 6 + 10 + 6 + RAND_OPS;
    localparam int CYCLE_LIMIT = 40 * NUM_REQS + 8;

    logic                             clk;
    logic                             rst;
    logic                             req_valid;
    dcache_pkg::cpu_req_t             req;
    logic                             busy;
    logic                             rsp_valid;
    logic [31:0]                      rsp_rdata;
    logic                             mem_rd_req;
    logic [31:0]                      mem_rd_addr;
    logic                             mem_rd_valid;
    logic [dcache_pkg::LINE_BITS-1:0] mem_rd_line;
    logic                             mem_wr_req;
    dcache_pkg::mem_wr_t              mem_wr;
    logic                             mem_wr_done;

    logic [31:0]         mem    [MEM_WORDS];
    logic [31:0]         shadow [MEM_WORDS];
    logic [31:0]         rng_state = 32'd34049;
    logic [31:0]         delay_state;
    logic [31:0]         rd_addr_q;
    dcache_pkg::mem_wr_t wr_q;
    int                  rd_wait = 0;
    int                  wr_wait = 0;
    int                  cycle_count = 0;
    int                  checks = 0;
    int                  errors = 0;

    dcache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_done  (mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Words are returned from the given word address upward, so an uncached word lands low
    function automatic logic [dcache_pkg::LINE_BITS-1:0] read_line(input logic [31:0] addr);
        logic [dcache_pkg::LINE_BITS-1:0] line;
        logic [13:0]                      idx;
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            idx = addr[15:2] + 14'(i);
            line[i*32 +: 32] = mem[idx];
        end
        return line;
    endfunction

    task automatic write_mem(input dcache_pkg::mem_wr_t wr);
        logic [13:0] idx;
        idx = wr.addr[15:2];
        if (wr.uncache) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) begin
                    mem[idx][b*8 +: 8] = wr.data[b*8 +: 8];
                end
            end
        end else begin
            for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
                mem[idx + 14'(i)] = wr.data[i*32 +: 32];
            end
        end
    endtask

    // Memory model answers each request after 1 to 6 cycles
    always @(negedge clk) begin
        mem_rd_valid = 1'b0;
        mem_wr_done  = 1'b0;
        if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                mem_rd_line  = read_line(rd_addr_q);
                mem_rd_valid = 1'b1;
            end
        end
        if (wr_wait > 0) begin
            wr_wait = wr_wait - 1;
            if (wr_wait == 0) begin
                write_mem(wr_q);
                mem_wr_done = 1'b1;
            end
        end
        if (mem_rd_req) begin
            rd_addr_q   = mem_rd_addr;
            delay_state = xorshift32(delay_state);
            rd_wait     = 1 + int'(delay_state % 6);
        end
        if (mem_wr_req) begin
            wr_q        = mem_wr;
            delay_state = xorshift32(delay_state);
            wr_wait     = 1 + int'(delay_state % 6);
        end
    end

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return 32'((tag << 10) | (set << 6) | (word << 2));
    endfunction

    function automatic logic [3:0] lane_mask(input logic [3:0] size, input logic [1:0] off);
        if (size == dcache_pkg::SIZE_BYTE) begin
            return 4'b0001 << off;
        end else if (size == dcache_pkg::SIZE_HALF && !off[0]) begin
            return 4'b0011 << off;
        end else if (size == dcache_pkg::SIZE_WORD && off == 2'd0) begin
            return 4'b1111;
        end
        return 4'b0000;
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [3:0] size,
                                               input logic [1:0] off, input logic sext);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = word[off[1]*16 +: 16];
        if (size == dcache_pkg::SIZE_BYTE) begin
            return {{24{b[7] & sext}}, b};
        end else if (size == dcache_pkg::SIZE_HALF && !off[0]) begin
            return {{16{h[15] & sext}}, h};
        end else if (size == dcache_pkg::SIZE_WORD && off == 2'd0) begin
            return word;
        end
        return 32'h0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Latency counts clock edges from the accepting edge to the one that raises rsp_valid
    task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata, input logic wr,
                              input logic [3:0] size, input logic sext, input logic uc,
                              output logic [31:0] rdata, output int lat);
        int k;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        req.addr       = addr;
        req.wdata      = wdata;
        req.wr         = wr;
        req.size       = size;
        req.signed_ext = sext;
        req.uncache    = uc;
        req_valid      = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        k = 1;
        // Busy covers every cycle from the one after acceptance through the response
        check_value("busy", 32'(busy), 32'h1);
        while (!rsp_valid) begin
            @(negedge clk);
            k++;
            check_value("busy", 32'(busy), 32'h1);
        end
        rdata = rsp_rdata;
        lat   = k - 1;
    endtask

    task automatic do_load(input logic [31:0] addr, input logic [3:0] size, input logic sext,
                           input logic uc, output int lat);
        logic [31:0] got;
        logic [31:0] exp;
        cpu_access(addr, 32'h0, 1'b0, size, sext, uc, got, lat);
        exp = uc ? shadow[addr[15:2]] : load_value(shadow[addr[15:2]], size, addr[1:0], sext);
        check_value("rsp_rdata", got, exp);
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] size, input logic uc);
        logic [31:0] rdata;
        logic [3:0]  mask;
        int          lat;
        mask = lane_mask(size, addr[1:0]);
        cpu_access(addr, wdata, 1'b1, size, 1'b0, uc, rdata, lat);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                shadow[addr[15:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic cold_loads();
        logic [31:0] addr;
        int          lat;
        for (int s = 0; s < 4; s++) begin
            addr = make_addr(s % 3, 1 + 3 * s, 5 * s);
            do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
            do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
            checks++;
            assert (lat == 2) else begin
                errors++;
                $display("Repeated load at 0x%08h answered %0d cycles after acceptance, not 2",
                         addr, lat);
            end
        end
    endtask

    task automatic sub_word_loads();
        logic [31:0] addr;
        int          lat;
        addr = make_addr(1, 2, 3);
        do_store(addr, 32'h7A80_F102, dcache_pkg::SIZE_WORD, 1'b0);
        for (int off = 0; off < 4; off++) begin
            do_load(addr + off, dcache_pkg::SIZE_BYTE, 1'b0, 1'b0, lat);
            do_load(addr + off, dcache_pkg::SIZE_BYTE, 1'b1, 1'b0, lat);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_load(addr + off, dcache_pkg::SIZE_HALF, 1'b0, 1'b0, lat);
            do_load(addr + off, dcache_pkg::SIZE_HALF, 1'b1, 1'b0, lat);
        end
        // Misaligned half
        do_load(addr + 1, dcache_pkg::SIZE_HALF, 1'b1, 1'b0, lat);
    endtask

    task automatic store_merge();
        logic [31:0] addr;
        int          lat;
        addr = make_addr(0, 5, 9);
        do_store(addr + 3, 32'hA500_0000, dcache_pkg::SIZE_BYTE, 1'b0);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
        do_store(addr + 2, 32'h5A3C_0000, dcache_pkg::SIZE_HALF, 1'b0);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
        do_store(addr, 32'h1357_9BDF, dcache_pkg::SIZE_WORD, 1'b0);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
    endtask

    // Five lines in one 4-way set force a dirty eviction
    task automatic set_conflict();
        int lat;
        for (int t = 0; t < 5; t++) begin
            do_store(make_addr(t, 11, 3 * t), next_rand(), dcache_pkg::SIZE_WORD, 1'b0);
        end
        for (int t = 0; t < 5; t++) begin
            do_load(make_addr(t, 11, 3 * t), dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
        end
    endtask

    task automatic uncached_access();
        logic [31:0] addr;
        logic [31:0] got;
        int          lat;
        addr = make_addr(2, 13, 6);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
        // Memory changes under the cached copy while the shadow keeps the cached view
        cpu_access(addr, 32'h1234_56F8, 1'b1, dcache_pkg::SIZE_WORD, 1'b0, 1'b1, got, lat);
        cpu_access(addr, 32'h0, 1'b0, dcache_pkg::SIZE_BYTE, 1'b1, 1'b1, got, lat);
        check_value("rsp_rdata", got, 32'h1234_56F8);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
        do_store(addr, 32'h2468_ACE0, dcache_pkg::SIZE_WORD, 1'b0);
        do_load(addr, dcache_pkg::SIZE_WORD, 1'b0, 1'b0, lat);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  size;
        logic [1:0]  off;
        logic        uc;
        int          lat;
        for (int n = 0; n < RAND_OPS; n++) begin
            r  = next_rand();
            uc = (r[2:0] == 3'd0);
            if (r[5:4] == 2'd0) begin
                size = dcache_pkg::SIZE_BYTE;
                off  = r[7:6];
            end else if (r[5:4] == 2'd1) begin
                size = dcache_pkg::SIZE_HALF;
                off  = {r[7], 1'b0};
            end else begin
                size = dcache_pkg::SIZE_WORD;
                off  = 2'd0;
            end
            // A small uncached window so that partial uncached stores are read back
            if (uc) begin
                addr = 32'h8000 + {r[11:8], 2'b00} + off;
            end else begin
                addr = make_addr(r[17:16] % 3, r[21:18], r[25:22]) + off;
            end
            if (r[26]) begin
                do_store(addr, next_rand(), size, uc);
            end else begin
                do_load(addr, size, r[27], uc, lat);
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        mem_rd_valid = 1'b0;
        mem_rd_line  = '0;
        mem_wr_done  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = next_rand();
            shadow[i] = mem[i];
        end
        delay_state = next_rand();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("busy", 32'(busy), 32'h0);
        check_value("rsp_valid", 32'(rsp_valid), 32'h0);
        check_value("mem_rd_req", 32'(mem_rd_req), 32'h0);
        check_value("mem_wr_req", 32'(mem_wr_req), 32'h0);

        cold_loads();
        sub_word_loads();
        store_merge();
        set_conflict();
        uncached_access();
        random_mix();

        errors = errors + DUT.u_ctrl.u_ctrl_asserts.fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_ctrl_asserts (
    input logic clk,
    input logic rst,
    input logic held,
    input logic rsp_valid,
    input logic mem_rd_req,
    input logic mem_rd_valid,
    input logic mem_wr_req,
    input logic mem_wr_done
);

    logic rd_open;
    logic wr_open;
    int   fails = 0;

    // A memory transaction is open from its request until its answer
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_open <= 1'b0;
            wr_open <= 1'b0;
        end else begin
            if (mem_rd_req) begin
                rd_open <= 1'b1;
            end else if (mem_rd_valid) begin
                rd_open <= 1'b0;
            end
            if (mem_wr_req) begin
                wr_open <= 1'b1;
            end else if (mem_wr_done) begin
                wr_open <= 1'b0;
            end
        end
    end

    rsp_pulse: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
        else begin
            $error("rsp_valid stayed high for more than one cycle");
            fails++;
        end

    rd_single: assert property (@(posedge clk) disable iff (rst) rd_open |-> !mem_rd_req)
        else begin
            $error("mem_rd_req raised again before mem_rd_valid");
            fails++;
        end

    wr_single: assert property (@(posedge clk) disable iff (rst) wr_open |-> !mem_wr_req)
        else begin
            $error("mem_wr_req raised again before mem_wr_done");
            fails++;
        end

    rsp_held: assert property (@(posedge clk) disable iff (rst) rsp_valid |-> held)
        else begin
            $error("rsp_valid high while no request is held");
            fails++;
        end

endmodule

bind dcache_ctrl dcache_ctrl_asserts u_ctrl_asserts (
    .clk          (clk),
    .rst          (rst),
    .held         (held),
    .rsp_valid    (rsp_valid),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_valid (mem_rd_valid),
    .mem_wr_req   (mem_wr_req),
    .mem_wr_done  (mem_wr_done)
);

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid,
    input  dcache_pkg::cpu_req_t             req,
    output logic                             busy,
    output logic                             rsp_valid,
    output logic [31:0]                      rsp_rdata,
    output logic                             mem_rd_req,
    output logic [31:0]                      mem_rd_addr,
    input  logic                             mem_rd_valid,
    input  logic [dcache_pkg::LINE_BITS-1:0] mem_rd_line,
    output logic                             mem_wr_req,
    output dcache_pkg::mem_wr_t              mem_wr,
    input  logic                             mem_wr_done
);

    dcache_pkg::cpu_req_t                              rbuf;
    logic                                              held;
    logic                                              hit;
    dcache_pkg::way_sel_t                              hit_way;
    dcache_pkg::way_sel_t                              victim_way;
    logic                                              victim_dirty;
    logic [dcache_pkg::TAG_BITS-1:0]                   victim_tag;
    logic [dcache_pkg::WAYS*dcache_pkg::LINE_BITS-1:0] set_lines;
    logic                                              refill_we;
    logic [dcache_pkg::LINE_BITS-1:0]                  refill_line;
    logic                                              store_we;
    logic                                              from_mem;
    logic [31:0]                                       rdata;
    logic [dcache_pkg::LINE_BITS-1:0]                  wr_line;

    dcache_req_buf u_req_buf (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (rsp_valid),
        .held      (held),
        .rbuf      (rbuf)
    );

    dcache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .rbuf         (rbuf),
        .refill_we    (refill_we),
        .refill_line  (refill_line),
        .store_we     (store_we),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .set_lines    (set_lines)
    );

    dcache_rd_sel u_rd_sel (
        .rbuf        (rbuf),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .set_lines   (set_lines),
        .mem_rd_line (mem_rd_line),
        .from_mem    (from_mem),
        .rdata       (rdata),
        .wr_line     (wr_line)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rbuf         (rbuf),
        .held         (held),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .wr_line      (wr_line),
        .rdata        (rdata),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .refill_we    (refill_we),
        .refill_line  (refill_line),
        .store_we     (store_we),
        .from_mem     (from_mem),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_done  (mem_wr_done)
    );

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  dcache_pkg::cpu_req_t             rbuf,
    input  logic                             held,
    input  logic                             hit,
    input  logic                             victim_dirty,
    input  logic [dcache_pkg::TAG_BITS-1:0]  victim_tag,
    input  logic [dcache_pkg::LINE_BITS-1:0] wr_line,
    input  logic [31:0]                      rdata,
    output logic                             busy,
    output logic                             rsp_valid,
    output logic [31:0]                      rsp_rdata,
    output logic                             refill_we,
    output logic [dcache_pkg::LINE_BITS-1:0] refill_line,
    output logic                             store_we,
    output logic                             from_mem,
    output logic                             mem_rd_req,
    output logic [31:0]                      mem_rd_addr,
    input  logic                             mem_rd_valid,
    input  logic [dcache_pkg::LINE_BITS-1:0] mem_rd_line,
    output logic                             mem_wr_req,
    output dcache_pkg::mem_wr_t              mem_wr,
    input  logic                             mem_wr_done
);

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        RF_REQ,
        RF_WAIT,
        UC_REQ,
        UC_WAIT,
        RESP
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [31:0]                     rsp_word_q;
    logic [dcache_pkg::SET_BITS-1:0] set_idx;
    logic [31:0]                     word_addr;
    logic [31:0]                     line_addr;

    assign set_idx   = rbuf.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::SET_BITS];
    assign word_addr = {rbuf.addr[31:2], 2'b00};
    assign line_addr = {rbuf.addr[31:dcache_pkg::OFFSET_BITS], {dcache_pkg::OFFSET_BITS{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (held) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (rbuf.uncache) begin
                    state_d = UC_REQ;
                end else if (hit) begin
                    state_d = RESP;
                end else if (victim_dirty) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = RF_REQ;
                end
            end
            WB_REQ:  state_d = WB_WAIT;
            WB_WAIT: begin
                if (mem_wr_done) begin
                    state_d = RF_REQ;
                end
            end
            RF_REQ:  state_d = RF_WAIT;
            // The refilled line is looked up again and then answers as a hit
            RF_WAIT: begin
                if (mem_rd_valid) begin
                    state_d = LOOKUP;
                end
            end
            UC_REQ:  state_d = UC_WAIT;
            UC_WAIT: begin
                if (rbuf.wr ? mem_wr_done : mem_rd_valid) begin
                    state_d = RESP;
                end
            end
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Load data is held here so the response can follow one cycle later
    always_ff @(posedge clk) begin
        if ((state_q == LOOKUP && hit) || (state_q == UC_WAIT && mem_rd_valid)) begin
            rsp_word_q <= rdata;
        end
    end

    assign busy      = held;
    assign rsp_valid = (state_q == RESP);
    assign rsp_rdata = rsp_word_q;

    // A store hit lands on the same edge that enters RESP
    assign store_we    = (state_q == LOOKUP) && hit && rbuf.wr && !rbuf.uncache;
    assign refill_we   = (state_q == RF_WAIT) && mem_rd_valid;
    assign refill_line = mem_rd_line;
    assign from_mem    = (state_q == UC_WAIT);

    assign mem_rd_req  = (state_q == RF_REQ) || (state_q == UC_REQ && !rbuf.wr);
    assign mem_rd_addr = rbuf.uncache ? word_addr : line_addr;
    assign mem_wr_req  = (state_q == WB_REQ) || (state_q == UC_REQ && rbuf.wr);

    always_comb begin
        mem_wr.data    = wr_line;
        mem_wr.uncache = rbuf.uncache;
        if (rbuf.uncache) begin
            mem_wr.addr = word_addr;
            mem_wr.strb = dcache_pkg::byte_mask(rbuf.size, rbuf.addr[1:0]);
        end else begin
            mem_wr.addr = {victim_tag, set_idx, {dcache_pkg::OFFSET_BITS{1'b0}}};
            mem_wr.strb = '0;
        end
    end

endmodule

// File: rtl/dcache_rd_sel.sv
`timescale 1ns/1ps

module dcache_rd_sel (
    input  dcache_pkg::cpu_req_t                            rbuf,
    input  dcache_pkg::way_sel_t                            hit_way,
    input  dcache_pkg::way_sel_t                            victim_way,
    input  logic [dcache_pkg::WAYS*dcache_pkg::LINE_BITS-1:0] set_lines,
    input  logic [dcache_pkg::LINE_BITS-1:0]                mem_rd_line,
    input  logic                                            from_mem,
    output logic [31:0]                                     rdata,
    output logic [dcache_pkg::LINE_BITS-1:0]                wr_line
);

    logic [dcache_pkg::LINE_BITS-1:0]     hit_line;
    logic [dcache_pkg::LINE_BITS-1:0]     victim_line;
    logic [dcache_pkg::WORD_IDX_BITS-1:0] word_idx;
    logic [31:0]                          word;
    logic [7:0]                           byte_val;
    logic [15:0]                          half_val;

    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (hit_way[w]) begin
                hit_line = set_lines[w*dcache_pkg::LINE_BITS +: dcache_pkg::LINE_BITS];
            end
            if (victim_way[w]) begin
                victim_line = set_lines[w*dcache_pkg::LINE_BITS +: dcache_pkg::LINE_BITS];
            end
        end
    end

    assign word_idx = rbuf.addr[2 +: dcache_pkg::WORD_IDX_BITS];

    // Memory puts an uncached word in the low lane of the line
    assign word = from_mem ? mem_rd_line[31:0] : hit_line[word_idx*32 +: 32];

    assign byte_val = word[rbuf.addr[1:0]*8 +: 8];
    assign half_val = word[rbuf.addr[1]*16 +: 16];

    always_comb begin
        if (rbuf.uncache) begin
            rdata = word;
        end else begin
            case (rbuf.size)
                dcache_pkg::SIZE_BYTE: begin
                    rdata = {{24{byte_val[7] & rbuf.signed_ext}}, byte_val};
                end
                dcache_pkg::SIZE_HALF: begin
                    if (rbuf.addr[0]) begin
                        rdata = '0;
                    end else begin
                        rdata = {{16{half_val[15] & rbuf.signed_ext}}, half_val};
                    end
                end
                dcache_pkg::SIZE_WORD: begin
                    rdata = (rbuf.addr[1:0] == 2'd0) ? word : '0;
                end
                default: rdata = '0;
            endcase
        end
    end

    // Uncached store data rides in the low word, memory takes the byte mask
    assign wr_line = rbuf.uncache ? {{(dcache_pkg::LINE_BITS - 32){1'b0}}, rbuf.wdata}
                                  : victim_line;

endmodule

// File: rtl/dcache_store.sv
`timescale 1ns/1ps

module dcache_store (
    input  logic                                            clk,
    input  logic                                            rst,
    input  dcache_pkg::cpu_req_t                            rbuf,
    input  logic                                            refill_we,
    input  logic [dcache_pkg::LINE_BITS-1:0]                refill_line,
    input  logic                                            store_we,
    output logic                                            hit,
    output dcache_pkg::way_sel_t                            hit_way,
    output dcache_pkg::way_sel_t                            victim_way,
    output logic                                            victim_dirty,
    output logic [dcache_pkg::TAG_BITS-1:0]                 victim_tag,
    output logic [dcache_pkg::WAYS*dcache_pkg::LINE_BITS-1:0] set_lines
);

    logic [dcache_pkg::TAG_BITS-1:0]  tag_mem  [dcache_pkg::SETS][dcache_pkg::WAYS];
    logic [dcache_pkg::LINE_BITS-1:0] data_mem [dcache_pkg::SETS][dcache_pkg::WAYS];
    dcache_pkg::way_sel_t             valid_q  [dcache_pkg::SETS];
    dcache_pkg::way_sel_t             dirty_q  [dcache_pkg::SETS];
    logic [dcache_pkg::RR_BITS-1:0]   rr_q     [dcache_pkg::SETS];

    logic [dcache_pkg::SET_BITS-1:0]      set_idx;
    logic [dcache_pkg::TAG_BITS-1:0]      req_tag;
    logic [dcache_pkg::WORD_IDX_BITS-1:0] word_idx;
    logic [3:0]                           mask;

    assign set_idx  = rbuf.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::SET_BITS];
    assign req_tag  = rbuf.addr[31 -: dcache_pkg::TAG_BITS];
    assign word_idx = rbuf.addr[2 +: dcache_pkg::WORD_IDX_BITS];
    assign mask     = dcache_pkg::byte_mask(rbuf.size, rbuf.addr[1:0]);

    // Arrays read combinationally, so the lookup sits in the cycle after capture
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            hit_way[w] = valid_q[set_idx][w] && (tag_mem[set_idx][w] == req_tag);
            set_lines[w*dcache_pkg::LINE_BITS +: dcache_pkg::LINE_BITS] = data_mem[set_idx][w];
        end
    end

    assign hit = |hit_way;

    // Lowest invalid way first, otherwise the round-robin pointer of the set
    always_comb begin
        victim_way = dcache_pkg::way_sel_t'(1) << rr_q[set_idx];
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set_idx][w]) begin
                victim_way = '0;
                victim_way[w] = 1'b1;
            end
        end
    end

    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (victim_way[w]) begin
                victim_tag = tag_mem[set_idx][w];
            end
        end
    end

    assign victim_dirty = |(victim_way & dirty_q[set_idx]);

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (refill_we && victim_way[w]) begin
                data_mem[set_idx][w] <= refill_line;
                tag_mem[set_idx][w]  <= req_tag;
            end else if (store_we && hit_way[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) begin
                        data_mem[set_idx][w][word_idx*32 + b*8 +: 8] <= rbuf.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (refill_we) begin
            valid_q[set_idx] <= valid_q[set_idx] | victim_way;
            dirty_q[set_idx] <= dirty_q[set_idx] & ~victim_way;
            rr_q[set_idx]    <= rr_q[set_idx] + 1'b1;
        end else if (store_we && (|mask)) begin
            // A misaligned store changes nothing, so the line stays clean
            dirty_q[set_idx] <= dirty_q[set_idx] | hit_way;
        end
    end

endmodule

// File: rtl/dcache_req_buf.sv
`timescale 1ns/1ps

module dcache_req_buf (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 busy,
    input  logic                 done,
    output logic                 held,
    output dcache_pkg::cpu_req_t rbuf
);

    logic accept;

    // A strobe that arrives while busy is dropped
    assign accept = req_valid && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (done) begin
            held <= 1'b0;
        end
    end

    // The request stays put for the whole miss or uncached sequence
    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= req;
        end
    end

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int WAYS = 4;
    localparam int SETS = 16;
    localparam int LINE_BITS = 512;
    localparam int WORDS_PER_LINE = 16;
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int SET_BITS = $clog2(SETS);
    localparam int WORD_IDX_BITS = $clog2(WORDS_PER_LINE);
    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;
    localparam int RR_BITS = $clog2(WAYS);

    // Access sizes are byte-enable masks for an aligned access at offset zero
    localparam logic [3:0] SIZE_BYTE = 4'b0001;
    localparam logic [3:0] SIZE_HALF = 4'b0011;
    localparam logic [3:0] SIZE_WORD = 4'b1111;

    typedef logic [WAYS-1:0] way_sel_t;

    // Store data in wdata is already placed in its byte lanes
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
        logic [3:0]  size;
        logic        signed_ext;
        logic        uncache;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0]          addr;
        logic [LINE_BITS-1:0] data;
        logic [3:0]           strb;
        logic                 uncache;
    } mem_wr_t;

    // Byte enables of an access, all clear when it is misaligned or the size is unknown
    function automatic logic [3:0] byte_mask(input logic [3:0] size, input logic [1:0] off);
        logic [3:0] mask;
        case (size)
            SIZE_BYTE: mask = SIZE_BYTE << off;
            SIZE_HALF: mask = off[0] ? 4'b0000 : SIZE_HALF << off;
            SIZE_WORD: mask = (off == 2'd0) ? SIZE_WORD : 4'b0000;
            default:   mask = 4'b0000;
        endcase
        return mask;
    endfunction

endpackage
